/* source/unpack_pkg.sv */
// unpacker package
// word, width and level sizes shared by the FIFOs and the unpacker
package unpack_pkg;

  // bits per packed and unpacked word
  localparam int DATA_W = 21;

  // holds a field width from 0 up to DATA_W
  localparam int WIDTH_W = $clog2(DATA_W) + 1;

  // bit FIFO holds two whole words
  localparam int BFIFO_BITS = 2 * DATA_W;

  // holds a bit FIFO level from 0 up to BFIFO_BITS
  localparam int LEVEL_W = $clog2(BFIFO_BITS) + 1;

  // word FIFO geometry
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);

endpackage

/* source/bfifo_if.sv */
// bit FIFO link
// push and pop sides between the unpacker control and the bit store
`timescale 1ns/1ps

interface bfifo_if;

  // push side, levels count free bits
  logic                              push;
  logic [unpack_pkg::WIDTH_W-1:0]    push_width;
  logic [unpack_pkg::DATA_W-1:0]     push_data;
  logic [unpack_pkg::LEVEL_W-1:0]    push_level;

  // pop side, levels count stored bits
  logic                              pop;
  logic [unpack_pkg::WIDTH_W-1:0]    pop_width;
  logic [unpack_pkg::DATA_W-1:0]     pop_data;
  logic [unpack_pkg::LEVEL_W-1:0]    pop_level;

  modport ctrl (
    output push, push_width, push_data,
    output pop, pop_width,
    input  push_level, pop_level, pop_data
  );

  modport store (
    input  push, push_width, push_data,
    input  pop, pop_width,
    output push_level, pop_level, pop_data
  );

endinterface

/* source/word_fifo.sv */
// word FIFO
// circular buffer with write and read strobes and registered read data
`timescale 1ns/1ps

module word_fifo (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // write side
  input  logic                          write_i,
  input  logic [unpack_pkg::DATA_W-1:0] wdata_i,
  output logic                          full_o,
  // read side
  input  logic                          read_i,
  output logic [unpack_pkg::DATA_W-1:0] rdata_o,
  output logic                          empty_o
);

  // pointers carry one extra wrap bit
  logic [unpack_pkg::FIFO_AW:0]  wptr_q;
  logic [unpack_pkg::FIFO_AW:0]  rptr_q;
  logic [unpack_pkg::DATA_W-1:0] mem_q [unpack_pkg::FIFO_DEPTH];
  logic                          wr_en;
  logic                          rd_en;

  assign empty_o = (wptr_q == rptr_q);

  // same slot, different lap
  assign full_o = (wptr_q[unpack_pkg::FIFO_AW-1:0] == rptr_q[unpack_pkg::FIFO_AW-1:0]) &&
                  (wptr_q[unpack_pkg::FIFO_AW] != rptr_q[unpack_pkg::FIFO_AW]);

  assign wr_en = write_i & ~full_o;
  assign rd_en = read_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (wr_en) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (rd_en) begin
        rptr_q <= rptr_q + 1'b1;
      end
    end
  end

  // storage and read register
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wptr_q[unpack_pkg::FIFO_AW-1:0]] <= wdata_i;
    end
    // read data is held until the next accepted read
    if (rd_en) begin
      rdata_o <= mem_q[rptr_q[unpack_pkg::FIFO_AW-1:0]];
    end
  end

endmodule

/* source/bit_fifo.sv */
// bit FIFO
// bit-granular store of two words, pushes and pops of variable width
`timescale 1ns/1ps

module bit_fifo (
  input  logic   clk_i,
  input  logic   rst_n_i,
  bfifo_if.store bf
);

  // stored bits, oldest at bit 0
  logic [unpack_pkg::BFIFO_BITS-1:0] store_q;
  logic [unpack_pkg::BFIFO_BITS-1:0] store_d;
  logic [unpack_pkg::LEVEL_W-1:0]    fill_q;
  logic [unpack_pkg::LEVEL_W-1:0]    fill_d;

  // state once the pop has been taken out
  logic [unpack_pkg::BFIFO_BITS-1:0] kept;
  logic [unpack_pkg::LEVEL_W-1:0]    kept_fill;

  // pushed bits moved up to the fill point
  logic [unpack_pkg::BFIFO_BITS-1:0] push_field;

  // width masks
  logic [unpack_pkg::DATA_W-1:0]     pop_mask;
  logic [unpack_pkg::DATA_W-1:0]     push_mask;

  always_comb begin
    pop_mask  = ~({unpack_pkg::DATA_W{1'b1}} << bf.pop_width);
    push_mask = ~({unpack_pkg::DATA_W{1'b1}} << bf.push_width);

    // pop first, zeros shift in from the top
    if (bf.pop) begin
      kept      = store_q >> bf.pop_width;
      kept_fill = fill_q - unpack_pkg::LEVEL_W'(bf.pop_width);
    end else begin
      kept      = store_q;
      kept_fill = fill_q;
    end

    // new bits land just above what is left
    push_field = unpack_pkg::BFIFO_BITS'(bf.push_data & push_mask) << kept_fill;

    if (bf.push) begin
      store_d = kept | push_field;
      fill_d  = kept_fill + unpack_pkg::LEVEL_W'(bf.push_width);
    end else begin
      store_d = kept;
      fill_d  = kept_fill;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      store_q <= '0;
      fill_q  <= '0;
    end else begin
      store_q <= store_d;
      fill_q  <= fill_d;
    end
  end

  // lowest bits, zero-extended
  assign bf.pop_data = store_q[unpack_pkg::DATA_W-1:0] & pop_mask;

  // levels
  assign bf.pop_level  = fill_q;
  assign bf.push_level = unpack_pkg::LEVEL_W'(unpack_pkg::BFIFO_BITS) - fill_q;

endmodule

/* source/bit_unpacker.sv */
// bit unpacker
// four-step loop feeding words into the bit FIFO and popping fields
`timescale 1ns/1ps

module bit_unpacker (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           wrap_i,
  input  logic [unpack_pkg::WIDTH_W-1:0] width_i,
  // packed words from the input FIFO
  output logic                           read_o,
  input  logic                           rready_i,
  input  logic [unpack_pkg::DATA_W-1:0]  rdata_i,
  // fields to the output FIFO
  output logic                           write_o,
  input  logic                           wready_i,
  output logic [unpack_pkg::DATA_W-1:0]  wdata_o
);

  typedef enum logic [1:0] {
    STEP_SPAN = 2'd0,
    STEP_WAIT = 2'd1,
    STEP_PUSH = 2'd2,
    STEP_POP  = 2'd3
  } step_e;

  step_e                          step_q;
  step_e                          step_d;

  // wrap span accumulator
  logic [unpack_pkg::WIDTH_W-1:0] span_q;
  logic [unpack_pkg::WIDTH_W-1:0] span_d;
  logic [unpack_pkg::WIDTH_W:0]   span_sum;

  logic [unpack_pkg::WIDTH_W-1:0] push_width;
  logic                           read;
  logic                           push;
  logic                           pop;

  bfifo_if bf ();

  // wrap mode keeps only the low span bits of each word
  assign push_width = wrap_i ? span_q : unpack_pkg::WIDTH_W'(unpack_pkg::DATA_W);
  assign span_sum   = {1'b0, span_q} + {1'b0, width_i};

  always_comb begin
    read   = 1'b0;
    push   = 1'b0;
    pop    = 1'b0;
    span_d = span_q;
    step_d = step_q;

    case (step_q)
      STEP_SPAN: begin
        // add width until the next field would overflow a word
        if (wrap_i && (span_sum <= unpack_pkg::DATA_W)) begin
          span_d = span_sum[unpack_pkg::WIDTH_W-1:0];
        end else begin
          step_d = STEP_WAIT;
        end
      end
      STEP_WAIT: begin
        if (rready_i && (bf.push_level >= unpack_pkg::LEVEL_W'(push_width))) begin
          read   = 1'b1;
          step_d = STEP_PUSH;
        end else begin
          step_d = STEP_POP;
        end
      end
      STEP_PUSH: begin
        // word from last cycle's read is now on rdata_i
        push   = 1'b1;
        step_d = STEP_POP;
      end
      default: begin
        if ((bf.pop_level >= unpack_pkg::LEVEL_W'(width_i)) && wready_i) begin
          pop = 1'b1;
        end
        step_d = STEP_WAIT;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      step_q <= STEP_SPAN;
      span_q <= '0;
    end else begin
      step_q <= step_d;
      span_q <= span_d;
    end
  end

  // bit FIFO control side
  assign bf.push       = push;
  assign bf.push_width = push_width;
  assign bf.push_data  = rdata_i;
  assign bf.pop        = pop;
  assign bf.pop_width  = width_i;

  bit_fifo bfifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bf      (bf.store)
  );

  assign read_o  = read;
  assign write_o = pop;
  assign wdata_o = bf.pop_data;

endmodule

/* source/unpack_top.sv */
// unpacker subsystem top
// input word FIFO, bit unpacker and output word FIFO in a chain
`timescale 1ns/1ps

module unpack_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // mode, held from reset
  input  logic                           wrap_i,
  input  logic [unpack_pkg::WIDTH_W-1:0] width_i,
  // packed word input
  input  logic                           in_write_i,
  input  logic [unpack_pkg::DATA_W-1:0]  in_data_i,
  output logic                           in_full_o,
  // unpacked field output
  input  logic                           out_read_i,
  output logic [unpack_pkg::DATA_W-1:0]  out_data_o,
  output logic                           out_empty_o
);

  logic                          in_read;
  logic                          in_empty;
  logic [unpack_pkg::DATA_W-1:0] in_rdata;

  logic                          out_write;
  logic                          out_full;
  logic [unpack_pkg::DATA_W-1:0] out_wdata;

  word_fifo in_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .write_i (in_write_i),
    .wdata_i (in_data_i),
    .full_o  (in_full_o),
    .read_i  (in_read),
    .rdata_o (in_rdata),
    .empty_o (in_empty)
  );

  // ready levels are the inverted FIFO flags
  bit_unpacker unpacker (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wrap_i   (wrap_i),
    .width_i  (width_i),
    .read_o   (in_read),
    .rready_i (~in_empty),
    .rdata_i  (in_rdata),
    .write_o  (out_write),
    .wready_i (~out_full),
    .wdata_o  (out_wdata)
  );

  word_fifo out_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .write_i (out_write),
    .wdata_i (out_wdata),
    .full_o  (out_full),
    .read_i  (out_read_i),
    .rdata_o (out_data_o),
    .empty_o (out_empty_o)
  );

endmodule

/* sim/unpack_tb.sv */
// unpacker testbench
// drives packed words into unpack_top and checks each field against a bit-queue model
`timescale 1ns/1ps

module unpack_tb;

  localparam int CLK_HALF     = 4;
  localparam int RESET_CYCLES = 16;
  localparam int QUIET_CYCLES = 100;
  localparam int N_TESTS      = 7;
  localparam int WORDS_PLAIN  = 60;
  localparam int WORDS_WIDE   = 20;
  localparam int WORDS_BIT    = 8;
  localparam int WORDS_WRAP   = 24;
  // input FIFO, bit FIFO and output FIFO together hold well under this
  localparam int WORDS_BP_MAX = 24;
  localparam int TOTAL_WORDS  = WORDS_PLAIN + WORDS_WIDE + WORDS_BIT +
                                2 * WORDS_WRAP + 2 * WORDS_BP_MAX;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + N_TESTS * RESET_CYCLES;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 wrap;
  logic [unpack_pkg::WIDTH_W-1:0]       width;
  logic                                 in_write;
  logic [unpack_pkg::DATA_W-1:0]        in_data;
  logic                                 in_full;
  logic                                 out_read;
  logic [unpack_pkg::DATA_W-1:0]        out_data;
  logic                                 out_empty;

  // reference stream with the oldest bit at the front
  bit                                   model_q[$];
  int                                   width_cfg;
  int                                   span_cfg;
  int                                   bits_sent;
  int                                   fields_read;
  integer                               seed;
  string                                test_name;

  // reader and check strobes
  logic                                 read_enable;
  logic                                 check_en;
  logic [unpack_pkg::DATA_W-1:0]        exp_field;
  logic                                 count_check;
  int                                   count_exp;
  int                                   count_got;

  unpack_top UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .wrap_i      (wrap),
    .width_i     (width),
    .in_write_i  (in_write),
    .in_data_i   (in_data),
    .in_full_o   (in_full),
    .out_read_i  (out_read),
    .out_data_o  (out_data),
    .out_empty_o (out_empty)
  );

  always #(CLK_HALF) clk = ~clk;

  task automatic announce_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
  endtask

  task automatic report_mismatch(input string check, input logic [31:0] expected,
                                 input logic [31:0] actual);
    announce_failure($sformatf("CHECK FAILED %s %s: expected %0h actual %0h",
                               test_name, check, expected, actual));
  endtask

  // reset state and the first cycle after release
  assert property (@(posedge clk) (!rst_n || !$past(rst_n)) |-> out_empty)
    else begin
      report_mismatch("out_empty in reset", 1, $sampled(out_empty));
      $fatal(1, "output FIFO not empty in reset");
    end

  assert property (@(posedge clk) (!rst_n || !$past(rst_n)) |-> !in_full)
    else begin
      report_mismatch("in_full in reset", 0, $sampled(in_full));
      $fatal(1, "input FIFO full in reset");
    end

  assert property (@(posedge clk) disable iff (!rst_n) check_en |-> (out_data == exp_field))
    else begin
      report_mismatch("field value", exp_field, $sampled(out_data));
      $fatal(1, "field mismatch");
    end

  assert property (@(posedge clk) disable iff (!rst_n) count_check |-> (count_got == count_exp))
    else begin
      report_mismatch("field count", count_exp, count_got);
      $fatal(1, "field count mismatch");
    end

  assert property (@(posedge clk) disable iff (!rst_n) in_full |-> !in_write)
    else begin
      report_mismatch("write while full", 0, $sampled(in_write));
      $fatal(1, "write attempted into a full input FIFO");
    end

  // output reader that compares the word one cycle after its read
  always @(posedge clk) begin
    int bit_idx;
    #1;
    check_en = 1'b0;
    // a read driven last cycle was taken at this edge
    if (out_read) begin
      if (model_q.size() < width_cfg) begin
        announce_failure("output FIFO delivered a field that the reference stream lacks");
        $fatal(1, "reference stream underflow");
      end else begin
        exp_field = '0;
        for (bit_idx = 0; bit_idx < width_cfg; bit_idx++) begin
          exp_field[bit_idx] = model_q.pop_front();
        end
        fields_read++;
        check_en = 1'b1;
      end
    end
    out_read = read_enable && rst_n && !out_empty;
  end

  task automatic apply_reset(input logic wrap_mode, input int field_width);
    @(posedge clk);
    #1;
    rst_n       = 1'b0;
    read_enable = 1'b0;
    in_write    = 1'b0;
    wrap        = wrap_mode;
    width       = unpack_pkg::WIDTH_W'(field_width);
    width_cfg   = field_width;
    // wrap span is the largest multiple of the width within a word
    if (wrap_mode) begin
      span_cfg = field_width * (unpack_pkg::DATA_W / field_width);
    end else begin
      span_cfg = unpack_pkg::DATA_W;
    end
    model_q.delete();
    bits_sent   = 0;
    fields_read = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // one random word into the input FIFO and its stream bits into the model
  task automatic drive_word();
    logic [unpack_pkg::DATA_W-1:0] word;
    int                            bit_idx;
    word     = $random(seed);
    in_write = 1'b1;
    in_data  = word;
    for (bit_idx = 0; bit_idx < span_cfg; bit_idx++) begin
      model_q.push_back(word[bit_idx]);
    end
    bits_sent += span_cfg;
  endtask

  task automatic send_words(input int n_words);
    int sent;
    sent = 0;
    while (sent < n_words) begin
      @(posedge clk);
      #1;
      if (in_full) begin
        in_write = 1'b0;
      end else begin
        drive_word();
        sent++;
      end
    end
    @(posedge clk);
    #1;
    in_write = 1'b0;
  endtask

  task automatic fill_until_full();
    logic full_seen;
    full_seen = 1'b0;
    while (!full_seen) begin
      @(posedge clk);
      #1;
      if (in_full) begin
        in_write  = 1'b0;
        full_seen = 1'b1;
      end else begin
        drive_word();
      end
    end
  endtask

  // wait for the unpacker to stall and compare the number of fields
  task automatic drain_and_count();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge clk);
      #1;
      if (out_empty) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    count_exp   = bits_sent / width_cfg;
    count_got   = fields_read;
    count_check = 1'b1;
    @(posedge clk);
    #1;
    count_check = 1'b0;
  endtask

  task automatic run_stream(input string name, input logic wrap_mode,
                            input int field_width, input int n_words);
    test_name = name;
    apply_reset(wrap_mode, field_width);
    read_enable = 1'b1;
    send_words(n_words);
    drain_and_count();
  endtask

  task automatic run_backpressure(input string name, input logic wrap_mode,
                                  input int field_width);
    test_name = name;
    apply_reset(wrap_mode, field_width);
    fill_until_full();
    read_enable = 1'b1;
    drain_and_count();
  endtask

  initial begin
    #(2 * CLK_HALF * WATCHDOG_CYCLES);
    announce_failure($sformatf("timeout: %s did not finish within %0d cycles",
                               test_name, WATCHDOG_CYCLES));
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b1;
    wrap        = 1'b0;
    width       = unpack_pkg::WIDTH_W'(1);
    in_write    = 1'b0;
    in_data     = '0;
    out_read    = 1'b0;
    read_enable = 1'b0;
    check_en    = 1'b0;
    exp_field   = '0;
    count_check = 1'b0;
    count_exp   = 0;
    count_got   = 0;
    width_cfg   = 1;
    span_cfg    = unpack_pkg::DATA_W;
    bits_sent   = 0;
    fields_read = 0;
    seed        = 32'he2fb;
    test_name   = "init";

    run_stream("plain_w5", 1'b0, 5, WORDS_PLAIN);
    run_stream("plain_w21", 1'b0, unpack_pkg::DATA_W, WORDS_WIDE);
    run_stream("plain_w1", 1'b0, 1, WORDS_BIT);
    // span 20 drops bit 20 while span 21 keeps every bit
    run_stream("wrap_w5", 1'b1, 5, WORDS_WRAP);
    run_stream("wrap_w7", 1'b1, 7, WORDS_WRAP);
    run_backpressure("backpressure_plain_w5", 1'b0, 5);
    run_backpressure("backpressure_wrap_w5", 1'b1, 5);

    $display("TEST PASS");
    $finish;
  end

endmodule

/* tb.f */
source/unpack_pkg.sv
source/bfifo_if.sv
source/word_fifo.sv
source/bit_fifo.sv
source/bit_unpacker.sv
source/unpack_top.sv
sim/unpack_tb.sv
